// File: src/bubl_cfg_pkg.sv
//----------------------------------------------------------------------
// Board configuration types and sizes shared by the bubl board blocks
//----------------------------------------------------------------------
`default_nettype none

package bubl_cfg_pkg;

    // Game variant bits taken from the download header
    typedef struct packed {
        logic bootleg;
        logic tokio;
    } variant_t;

    // Debug view selection
    typedef enum logic [1:0] {
        DBG_STATUS     = 2'd0,
        DBG_MAIN_LATCH = 2'd1,
        DBG_SND_LATCH  = 2'd2,
        DBG_NONE       = 2'd3
    } dbg_view_t;

    // Video RAM is 4 kB
    localparam int VRAM_AW = 12;

    // Palette RAM is 512 bytes
    localparam int PAL_AW = 9;

    // Header byte offset carrying the variant bits
    localparam logic [1:0] HDR_CFG_ADDR = 2'd0;

endpackage

`default_nettype wire

// File: src/bubl_bus_pkg.sv
//----------------------------------------------------------------------
// Bus and mailbox types for the main CPU and sound CPU ports
//----------------------------------------------------------------------
`default_nettype none

package bubl_bus_pkg;

    // Main CPU address width on the video side
    localparam int CPU_AW = 13;

    // Main CPU mailbox commands
    typedef enum logic [2:0] {
        MAIN_IDLE        = 3'd0,
        MAIN_WR_CMD      = 3'd1,
        MAIN_RD_REPLY    = 3'd2,
        MAIN_SET_SND_RST = 3'd3,
        MAIN_CLR_SND_RST = 3'd4
    } main_op_t;

    // Sound CPU mailbox commands
    typedef enum logic [1:0] {
        SND_IDLE     = 2'd0,
        SND_WR_REPLY = 2'd1,
        SND_RD_CMD   = 2'd2
    } snd_op_t;

    // Any op other than idle acts as a one-cycle strobe
    typedef struct packed {
        main_op_t    op;
        logic [7:0]  data;
    } main_req_t;

    typedef struct packed {
        snd_op_t     op;
        logic [7:0]  data;
    } snd_req_t;

    // Main CPU access to VRAM and palette
    typedef struct packed {
        logic [CPU_AW-1:0] addr;
        logic [7:0]        dout;
        logic              rnw;
        logic              vram_cs;
        logic              pal_cs;
    } cpu_bus_t;

    // Mailbox state as seen by both CPUs
    typedef struct packed {
        logic [7:0] snd_latch;
        logic [7:0] main_latch;
        logic       snd_flag;
        logic       main_flag;
        logic       snd_rst;
    } mbox_stat_t;

endpackage

`default_nettype wire

// File: src/bubl_board_ctrl.sv
//----------------------------------------------------------------------
// Game variant capture from the ROM download header and selection of
// the reset seen by the sound CPU
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bubl_board_ctrl
    import bubl_cfg_pkg::*;
(
    input  wire        clk,
    input  wire        rst,

    // ROM download port
    input  wire        prog_we,
    input  wire        header,
    input  wire  [7:0] prog_addr,
    input  wire  [7:0] prog_data,

    // Software sound reset held in the mailbox
    input  wire        snd_rst_req,

    output variant_t   variant,
    output logic       snd_rst_eff
);

    logic hdr_cfg_we;

    // Configuration byte sits at a fixed header offset
    assign hdr_cfg_we = prog_we && header && (prog_addr[1:0] == HDR_CFG_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            variant <= '0;
        end else if (hdr_cfg_we) begin
            variant.tokio   <= prog_data[0];
            variant.bootleg <= prog_data[1];
        end
    end

    // Tokio boards hold the sound CPU in reset under main CPU control,
    // the others simply follow the system reset
    assign snd_rst_eff = variant.tokio ? snd_rst_req : rst;

endmodule

`default_nettype wire

// File: src/bubl_mailbox.sv
//----------------------------------------------------------------------
// Two-way command mailbox between main and sound CPU, with pending
// flags and the software sound reset register
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bubl_mailbox
    import bubl_bus_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        snd_rst_eff,
    input  main_req_t  main_req,
    input  snd_req_t   snd_req,
    output mbox_stat_t mbox
);

    snd_op_t    snd_op;
    logic       main_wr;
    logic       main_rd;
    logic       snd_wr;
    logic       snd_rd;

    logic [7:0] snd_latch;
    logic [7:0] main_latch;
    logic       snd_flag;
    logic       main_flag;
    logic       snd_rst;

    // Sound side is deaf while held in reset
    assign snd_op  = snd_rst_eff ? SND_IDLE : snd_req.op;

    assign main_wr = (main_req.op == MAIN_WR_CMD);
    assign main_rd = (main_req.op == MAIN_RD_REPLY);
    assign snd_wr  = (snd_op == SND_WR_REPLY);
    assign snd_rd  = (snd_op == SND_RD_CMD);

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_latch  <= '0;
            main_latch <= '0;
            snd_flag   <= 1'b0;
            main_flag  <= 1'b0;
            snd_rst    <= 1'b0;
        end else begin
            // Main to sound direction, set wins over clear
            if (main_wr) begin
                snd_latch <= main_req.data;
                snd_flag  <= 1'b1;
            end else if (snd_rd) begin
                snd_flag  <= 1'b0;
            end

            // Sound to main direction
            if (snd_wr) begin
                main_latch <= snd_req.data;
            end
            if (snd_rst_eff) begin
                main_flag <= 1'b0;
            end else if (snd_wr) begin
                main_flag <= 1'b1;
            end else if (main_rd) begin
                main_flag <= 1'b0;
            end

            case (main_req.op)
                MAIN_SET_SND_RST: snd_rst <= 1'b1;
                MAIN_CLR_SND_RST: snd_rst <= 1'b0;
                default:          snd_rst <= snd_rst;
            endcase
        end
    end

    assign mbox.snd_latch  = snd_latch;
    assign mbox.main_latch = main_latch;
    assign mbox.snd_flag   = snd_flag;
    assign mbox.main_flag  = main_flag;
    assign mbox.snd_rst    = snd_rst;

endmodule

`default_nettype wire

// File: src/bubl_gfx_ram.sv
//----------------------------------------------------------------------
// CPU side of the video RAM and palette RAM, single port, with
// registered read data
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bubl_gfx_ram
    import bubl_cfg_pkg::*;
    import bubl_bus_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  cpu_bus_t   cpu_bus,
    output logic [7:0] vram_dout,
    output logic [7:0] pal_dout
);

    localparam int VRAM_SIZE = 1 << VRAM_AW;
    localparam int PAL_SIZE  = 1 << PAL_AW;

    logic [7:0]         vram_mem [VRAM_SIZE];
    logic [7:0]         pal_mem  [PAL_SIZE];

    logic [VRAM_AW-1:0] vram_addr;
    logic [PAL_AW-1:0]  pal_addr;
    logic               vram_we;
    logic               vram_re;
    logic               pal_we;
    logic               pal_re;

    // Both memories decode the low address bits only
    assign vram_addr = cpu_bus.addr[VRAM_AW-1:0];
    assign pal_addr  = cpu_bus.addr[PAL_AW-1:0];

    assign vram_we = cpu_bus.vram_cs && !cpu_bus.rnw;
    assign vram_re = cpu_bus.vram_cs &&  cpu_bus.rnw;
    assign pal_we  = cpu_bus.pal_cs  && !cpu_bus.rnw;
    assign pal_re  = cpu_bus.pal_cs  &&  cpu_bus.rnw;

    // Memory arrays
    always_ff @(posedge clk) begin
        if (vram_we) begin
            vram_mem[vram_addr] <= cpu_bus.dout;
        end
    end

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[pal_addr] <= cpu_bus.dout;
        end
    end

    // Read data holds until the next read of the same memory
    always_ff @(posedge clk) begin
        if (rst) begin
            vram_dout <= '0;
        end else if (vram_re) begin
            vram_dout <= vram_mem[vram_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pal_dout <= '0;
        end else if (pal_re) begin
            pal_dout <= pal_mem[pal_addr];
        end
    end

endmodule

`default_nettype wire

// File: src/bubl_debug_mux.sv
//----------------------------------------------------------------------
// Registered selector for the debug view byte
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bubl_debug_mux
    import bubl_cfg_pkg::*;
    import bubl_bus_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  dbg_view_t  debug_sel,
    input  variant_t   variant,
    input  wire        snd_rst_eff,
    input  mbox_stat_t mbox,
    output logic [7:0] debug_view
);

    always_ff @(posedge clk) begin
        if (rst) begin
            debug_view <= '0;
        end else begin
            case (debug_sel)
                // Status bits, bit 5 shows the sound CPU running
                DBG_STATUS:     debug_view <= {2'b00, ~snd_rst_eff, mbox.snd_rst,
                                               2'b00, variant.bootleg, variant.tokio};
                DBG_MAIN_LATCH: debug_view <= mbox.main_latch;
                DBG_SND_LATCH:  debug_view <= mbox.snd_latch;
                default:        debug_view <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/bubl_board.sv
//----------------------------------------------------------------------
// Board level glue of the game core: variant capture, sound mailbox,
// CPU side video memories and the debug view
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bubl_board
    import bubl_cfg_pkg::*;
    import bubl_bus_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    // ROM download
    input  wire         prog_we,
    input  wire         header,
    input  wire   [7:0] prog_addr,
    input  wire   [7:0] prog_data,

    // CPU ports
    input  main_req_t   main_req,
    input  snd_req_t    snd_req,
    input  cpu_bus_t    cpu_bus,

    input  dbg_view_t   debug_sel,

    output variant_t    variant,
    output wire         snd_rst_eff,
    output mbox_stat_t  mbox,
    output wire   [7:0] vram_dout,
    output wire   [7:0] pal_dout,
    output wire   [7:0] debug_view
);

    bubl_board_ctrl u_ctrl (
        .clk         ( clk          ),
        .rst         ( rst          ),
        .prog_we     ( prog_we      ),
        .header      ( header       ),
        .prog_addr   ( prog_addr    ),
        .prog_data   ( prog_data    ),
        .snd_rst_req ( mbox.snd_rst ),
        .variant     ( variant      ),
        .snd_rst_eff ( snd_rst_eff  )
    );

    bubl_mailbox u_mailbox (
        .clk         ( clk          ),
        .rst         ( rst          ),
        .snd_rst_eff ( snd_rst_eff  ),
        .main_req    ( main_req     ),
        .snd_req     ( snd_req      ),
        .mbox        ( mbox         )
    );

    bubl_gfx_ram u_gfx_ram (
        .clk         ( clk          ),
        .rst         ( rst          ),
        .cpu_bus     ( cpu_bus      ),
        .vram_dout   ( vram_dout    ),
        .pal_dout    ( pal_dout     )
    );

    bubl_debug_mux u_debug_mux (
        .clk         ( clk          ),
        .rst         ( rst          ),
        .debug_sel   ( debug_sel    ),
        .variant     ( variant      ),
        .snd_rst_eff ( snd_rst_eff  ),
        .mbox        ( mbox         ),
        .debug_view  ( debug_view   )
    );

endmodule

`default_nettype wire

// File: sim/bubl_board_assertions.sv
//----------------------------------------------------------------------
// Concurrent checks bound into the mailbox and the board control block
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bubl_board_assertions
    import bubl_bus_pkg::*;
(
    input wire        clk,
    input wire        rst,
    input wire        snd_rst_eff,
    input wire        tokio,
    input main_req_t  main_req,
    input snd_req_t   snd_req,
    input mbox_stat_t mbox
);

    // Whole mailbox state is clear right after a reset edge
    assert property (@(posedge clk) rst |=> (mbox == '0))
        else $error("mailbox state not cleared by reset");

    assert property (@(posedge clk) disable iff (rst)
        (main_req.op == MAIN_WR_CMD) |=> mbox.snd_flag)
        else $error("command write did not set snd_flag");

    assert property (@(posedge clk) disable iff (rst)
        (snd_req.op == SND_WR_REPLY && !snd_rst_eff) |=> mbox.main_flag)
        else $error("reply write did not set main_flag");

    // Flag is forced clear one cycle into the sound reset
    assert property (@(posedge clk) snd_rst_eff |=> !mbox.main_flag)
        else $error("main_flag high during sound reset");

    assert property (@(posedge clk) !tokio |-> (snd_rst_eff == rst))
        else $error("sound reset does not follow system reset");

endmodule

// Mailbox side, tokio tied high so the reset select check is idle
bind bubl_mailbox bubl_board_assertions u_mbox_chk (
    .clk(clk), .rst(rst), .snd_rst_eff(snd_rst_eff), .tokio(1'b1),
    .main_req(main_req), .snd_req(snd_req), .mbox(mbox)
);

bind bubl_board_ctrl bubl_board_assertions u_ctrl_chk (
    .clk(clk), .rst(rst), .snd_rst_eff(snd_rst_eff), .tokio(variant.tokio),
    .main_req('0), .snd_req('0), .mbox('0)
);

`default_nettype wire

// File: sim/bubl_board_tb.sv
//----------------------------------------------------------------------
// Testbench for the board glue: mailbox, variant, memories, debug view
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module bubl_board_tb
    import bubl_cfg_pkg::*;
    import bubl_bus_pkg::*;
();

    localparam int TIMEOUT = 20;

    logic       clk;
    logic       rst;
    logic       prog_we;
    logic       header;
    logic [7:0] prog_addr;
    logic [7:0] prog_data;
    main_req_t  main_req;
    snd_req_t   snd_req;
    cpu_bus_t   cpu_bus;
    dbg_view_t  debug_sel;
    variant_t   variant;
    logic       snd_rst_eff;
    mbox_stat_t mbox;
    logic [7:0] vram_dout;
    logic [7:0] pal_dout;
    logic [7:0] debug_view;

    mbox_stat_t exp_mbox;
    variant_t   exp_variant;
    logic [7:0] vram_shadow [1 << VRAM_AW];
    logic [7:0] pal_shadow [1 << PAL_AW];
    logic [31:0] lcg_state;
    string      cur_test;
    int         errors;
    int         tests;
    int         test_start_errors;

    bubl_board u_dut (
        .clk(clk), .rst(rst), .prog_we(prog_we), .header(header),
        .prog_addr(prog_addr), .prog_data(prog_data),
        .main_req(main_req), .snd_req(snd_req), .cpu_bus(cpu_bus),
        .debug_sel(debug_sel), .variant(variant), .snd_rst_eff(snd_rst_eff),
        .mbox(mbox), .vram_dout(vram_dout), .pal_dout(pal_dout),
        .debug_view(debug_view)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Next mailbox state from the handshake rules
    function automatic mbox_stat_t ref_mbox(input mbox_stat_t cur, input main_req_t m,
                                            input snd_req_t s, input logic eff);
        mbox_stat_t nxt;
        snd_op_t    sop;
        nxt = cur;
        sop = eff ? SND_IDLE : s.op;
        if (m.op == MAIN_WR_CMD) begin
            nxt.snd_latch = m.data;
            nxt.snd_flag  = 1'b1;
        end else if (sop == SND_RD_CMD) begin
            nxt.snd_flag = 1'b0;
        end
        if (sop == SND_WR_REPLY) begin
            nxt.main_latch = s.data;
            nxt.main_flag  = 1'b1;
        end else if (m.op == MAIN_RD_REPLY) begin
            nxt.main_flag = 1'b0;
        end
        if (eff) begin
            nxt.main_flag = 1'b0;
        end
        if (m.op == MAIN_SET_SND_RST) begin
            nxt.snd_rst = 1'b1;
        end else if (m.op == MAIN_CLR_SND_RST) begin
            nxt.snd_rst = 1'b0;
        end
        return nxt;
    endfunction

    function automatic logic ref_snd_rst(input variant_t v, input logic sw_rst, input logic r);
        return v.tokio ? sw_rst : r;
    endfunction

    function automatic logic [7:0] ref_debug(input dbg_view_t sel, input variant_t v,
                                             input logic eff, input mbox_stat_t m);
        case (sel)
            DBG_STATUS:     return {2'b00, !eff, m.snd_rst, 2'b00, v.bootleg, v.tokio};
            DBG_MAIN_LATCH: return m.main_latch;
            DBG_SND_LATCH:  return m.snd_latch;
            default:        return 8'h00;
        endcase
    endfunction

    task automatic check_mbox(input string name, input mbox_stat_t exp, input mbox_stat_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %h actual %h", cur_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_variant(input string name, input variant_t exp, input variant_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %b actual %b", cur_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %h actual %h", cur_test, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s expected %b actual %b", cur_test, name, exp, act);
            errors++;
        end
    endtask

    // Scoreboard: compare against the model, then advance it with the inputs
    // that the DUT samples on the coming edge
    always @(negedge clk) begin : scoreboard
        logic eff;
        if (!rst) begin
            check_mbox("mbox", exp_mbox, mbox);
            check_variant("variant", exp_variant, variant);
            check_bit("snd_rst_eff", ref_snd_rst(exp_variant, exp_mbox.snd_rst, rst),
                      snd_rst_eff);
        end
        if (rst) begin
            exp_mbox    = '0;
            exp_variant = '0;
        end else begin
            eff      = ref_snd_rst(exp_variant, exp_mbox.snd_rst, rst);
            exp_mbox = ref_mbox(exp_mbox, main_req, snd_req, eff);
            if (prog_we && header && prog_addr[1:0] == HDR_CFG_ADDR) begin
                exp_variant.tokio   = prog_data[0];
                exp_variant.bootleg = prog_data[1];
            end
        end
    end

    task automatic issue(input main_op_t mop, input logic [7:0] md,
                         input snd_op_t sop, input logic [7:0] sd);
        @(posedge clk);
        main_req <= '{op: mop, data: md};
        snd_req  <= '{op: sop, data: sd};
        @(posedge clk);
        main_req <= '{op: MAIN_IDLE, data: 8'h00};
        snd_req  <= '{op: SND_IDLE, data: 8'h00};
        @(negedge clk);
    endtask

    task automatic write_header(input logic hdr, input logic [7:0] addr, input logic [7:0] data);
        @(posedge clk);
        prog_we   <= 1'b1;
        header    <= hdr;
        prog_addr <= addr;
        prog_data <= data;
        @(posedge clk);
        prog_we <= 1'b0;
        header  <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_snd_rst_eff(input logic level);
        int n;
        n = 0;
        while (snd_rst_eff !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (snd_rst_eff !== level) begin
            $display("Timeout in %s: snd_rst_eff never reached %b", cur_test, level);
            errors++;
        end
    endtask

    task automatic mem_access(input logic vram, input logic rnw,
                              input logic [CPU_AW-1:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu_bus <= '{addr: addr, dout: data, rnw: rnw, vram_cs: vram, pal_cs: !vram};
        @(posedge clk);
        cpu_bus <= '{addr: '0, dout: 8'h00, rnw: 1'b1, vram_cs: 1'b0, pal_cs: 1'b0};
        @(negedge clk);
        if (!rnw && vram) begin
            vram_shadow[addr[VRAM_AW-1:0]] = data;
        end else if (!rnw) begin
            pal_shadow[addr[PAL_AW-1:0]] = data;
        end else if (vram) begin
            check_byte("vram_dout", vram_shadow[addr[VRAM_AW-1:0]], vram_dout);
        end else begin
            check_byte("pal_dout", pal_shadow[addr[PAL_AW-1:0]], pal_dout);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        tests++;
        $display("Test %s done, %0d errors", cur_test, errors - test_start_errors);
    endtask

    initial begin : stimulus
        logic [7:0]        d;
        logic [CPU_AW-1:0] addr_q [$];
        logic              kind_q [$];
        mbox_stat_t        saved;
        variant_t          known_var;
        dbg_view_t         sel;
        errors    = 0;
        tests     = 0;
        lcg_state = 32'h1328_f9c3;
        rst       = 1'b1;
        prog_we   = 1'b0;
        header    = 1'b0;
        prog_addr = 8'h00;
        prog_data = 8'h00;
        main_req  = '{op: MAIN_IDLE, data: 8'h00};
        snd_req   = '{op: SND_IDLE, data: 8'h00};
        cpu_bus   = '{addr: '0, dout: 8'h00, rnw: 1'b1, vram_cs: 1'b0, pal_cs: 1'b0};
        debug_sel = DBG_NONE;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        start_test("header_capture");
        write_header(1'b0, 8'h00, 8'h03);
        check_variant("header low", 2'b00, variant);
        write_header(1'b1, 8'h01, 8'h03);
        write_header(1'b1, 8'h02, 8'h01);
        write_header(1'b1, 8'h03, 8'h03);
        check_variant("other offsets", 2'b00, variant);
        write_header(1'b1, 8'h00, 8'h02);
        check_variant("config byte", 2'b10, variant);
        finish_test();

        start_test("main_to_sound");
        lcg_state = lcg_next(lcg_state);
        d = lcg_state[7:0];
        issue(MAIN_WR_CMD, d, SND_IDLE, 8'h00);
        check_byte("snd_latch", d, mbox.snd_latch);
        check_bit("snd_flag set", 1'b1, mbox.snd_flag);
        issue(MAIN_IDLE, 8'h00, SND_RD_CMD, 8'h00);
        check_bit("snd_flag clear", 1'b0, mbox.snd_flag);
        issue(MAIN_WR_CMD, ~d, SND_RD_CMD, 8'h00);
        check_byte("snd_latch same cycle", ~d, mbox.snd_latch);
        check_bit("set wins", 1'b1, mbox.snd_flag);
        issue(MAIN_IDLE, 8'h00, SND_RD_CMD, 8'h00);
        finish_test();

        start_test("sound_to_main");
        lcg_state = lcg_next(lcg_state);
        d = lcg_state[7:0];
        issue(MAIN_IDLE, 8'h00, SND_WR_REPLY, d);
        check_byte("main_latch", d, mbox.main_latch);
        check_bit("main_flag set", 1'b1, mbox.main_flag);
        issue(MAIN_RD_REPLY, 8'h00, SND_IDLE, 8'h00);
        check_bit("main_flag clear", 1'b0, mbox.main_flag);
        issue(MAIN_RD_REPLY, 8'h00, SND_WR_REPLY, ~d);
        check_bit("set wins", 1'b1, mbox.main_flag);
        issue(MAIN_RD_REPLY, 8'h00, SND_IDLE, 8'h00);
        finish_test();

        start_test("sound_reset");
        check_bit("tokio clear", 1'b0, snd_rst_eff);
        issue(MAIN_SET_SND_RST, 8'h00, SND_IDLE, 8'h00);
        check_bit("tokio clear, sw reset", 1'b0, snd_rst_eff);
        issue(MAIN_CLR_SND_RST, 8'h00, SND_IDLE, 8'h00);
        write_header(1'b1, 8'h00, 8'h01);
        check_bit("tokio set", 1'b0, snd_rst_eff);
        // Both flags pending, so a sound request that slips through shows up
        issue(MAIN_WR_CMD, 8'hc3, SND_WR_REPLY, 8'h3c);
        issue(MAIN_SET_SND_RST, 8'h00, SND_IDLE, 8'h00);
        wait_snd_rst_eff(1'b1);
        @(negedge clk);
        saved = '{snd_latch: 8'hc3, main_latch: 8'h3c,
                  snd_flag: 1'b1, main_flag: 1'b0, snd_rst: 1'b1};
        check_mbox("reset entry", saved, mbox);
        issue(MAIN_IDLE, 8'h00, SND_WR_REPLY, 8'h5a);
        issue(MAIN_IDLE, 8'h00, SND_RD_CMD, 8'h00);
        check_mbox("ignored in reset", saved, mbox);
        check_bit("main_flag held", 1'b0, mbox.main_flag);
        issue(MAIN_CLR_SND_RST, 8'h00, SND_IDLE, 8'h00);
        wait_snd_rst_eff(1'b0);
        finish_test();

        start_test("video_memories");
        for (int i = 0; i < 24; i++) begin
            lcg_state = lcg_next(lcg_state);
            addr_q.push_back(lcg_state[CPU_AW-1:0]);
            kind_q.push_back(lcg_state[20]);
            mem_access(lcg_state[20], 1'b0, lcg_state[CPU_AW-1:0], lcg_state[31:24]);
        end
        foreach (addr_q[i]) begin
            mem_access(kind_q[i], 1'b1, addr_q[i], 8'h00);
        end
        finish_test();

        start_test("debug_views");
        lcg_state = lcg_next(lcg_state);
        issue(MAIN_WR_CMD, lcg_state[7:0], SND_WR_REPLY, lcg_state[15:8]);
        known_var = 2'b01;
        saved = '{snd_latch: lcg_state[7:0], main_latch: lcg_state[15:8],
                  snd_flag: 1'b1, main_flag: 1'b1, snd_rst: 1'b0};
        for (int i = 0; i < 4; i++) begin
            sel = dbg_view_t'(i);
            @(posedge clk);
            debug_sel <= sel;
            @(posedge clk);
            @(negedge clk);
            check_byte("debug_view", ref_debug(sel, known_var, 1'b0, saved), debug_view);
        end
        finish_test();

        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bubl_board.f
src/bubl_cfg_pkg.sv
src/bubl_bus_pkg.sv
src/bubl_board_ctrl.sv
src/bubl_mailbox.sv
src/bubl_gfx_ram.sv
src/bubl_debug_mux.sv
src/bubl_board.sv
sim/bubl_board_assertions.sv
sim/bubl_board_tb.sv

// File: Makefile
# Verilator flow for the bubl board glue

TOP := bubl_board_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f bubl_board.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f bubl_board.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
